// ==== build.f ====
source/fv_pkg.sv
source/fv_sram.sv
source/fv_bank_arbiter.sv
source/fv_stream_reader.sv
source/fv_edge_reader.sv
source/fv_write_port.sv
source/fv_bank_top.sv
tests/fv_bank_props.sv
tests/fv_bank_tb.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv) $(wildcard tests/*.sv)

.PHONY: run clean

run: obj_dir/Vfv_bank_tb
	./obj_dir/Vfv_bank_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

obj_dir/Vfv_bank_tb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module fv_bank_tb \
		-Mdir obj_dir -o Vfv_bank_tb

clean:
	rm -rf obj_dir sim.log

// ==== tests/fv_bank_tb.sv ====
// testbench for the feature-value bank, operation table, reference memory,
// beat monitors and watchdog
`timescale 1ns/1ps
`default_nettype none

module fv_bank_tb;
    import fv_pkg::*;

    localparam int OP_WRITE  = 0;
    localparam int OP_EDGE   = 1;
    localparam int OP_STREAM = 2;
    localparam int OP_ITER   = 3;
    localparam int OP_BOTH   = 4;
    localparam int OP_IDLE   = 5;
    localparam int N_OPS     = 18;

    typedef struct packed {
        int op;
        int node;
        int tag;
        int it;
    } op_t;

    logic                        clk;
    logic                        reset;
    logic                        stream_begin;
    logic [ITER_WIDTH-1:0]       iter;
    logic                        rd_valid;
    logic [NODE_ID_WIDTH-1:0]    rd_node;
    logic [TAG_WIDTH-1:0]        rd_tag;
    logic                        wb_valid;
    logic [NODE_ID_WIDTH-1:0]    wb_node;
    logic [FV_WIDTH-1:0]         wb_data;
    logic                        wb_last;
    logic                        available;
    logic                        stream_valid;
    logic                        stream_sos;
    logic                        stream_eos;
    logic [STREAM_IDX_WIDTH-1:0] stream_idx;
    logic [FV_WIDTH-1:0]         stream_data;
    logic                        edge_valid;
    logic                        edge_sos;
    logic                        edge_eos;
    logic [TAG_WIDTH-1:0]        edge_tag;
    logic [FV_WIDTH-1:0]         edge_data;

    op_t                 ops [N_OPS];
    logic [FV_WIDTH-1:0] ref_mem [256];
    logic [FV_WIDTH-1:0] edge_q [$];
    logic [TAG_WIDTH-1:0] tag_q [$];
    logic [FV_WIDTH-1:0] stream_q [$];
    logic [31:0]         rng_state;
    int                  error_count;
    int                  edge_beat;
    int                  stream_beat;
    logic [FV_WIDTH-1:0] exp_data;
    logic [TAG_WIDTH-1:0] exp_tag;

    fv_bank_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure();
        error_count++;
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // wait until every expected beat arrived and the bank is free again
    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (!(edge_q.size() == 0 && stream_q.size() == 0 && available));
    endtask

    task automatic write_node(input int node);
        logic [FV_WIDTH-1:0] d;
        for (int b = 0; b < 4; b++) begin
            @(posedge clk);
            rng_state = xorshift(rng_state);
            d = rng_state;
            ref_mem[node * 4 + b] = d;
            wb_valid <= 1'b1;
            wb_node  <= NODE_ID_WIDTH'(node);
            wb_data  <= d;
            wb_last  <= (b == 3);
        end
        @(posedge clk);
        wb_valid <= 1'b0;
        wb_last  <= 1'b0;
        wait_idle();
    endtask

    task automatic expect_edge(input int node, input int tag);
        for (int b = 0; b < 4; b++) begin
            edge_q.push_back(ref_mem[node * 4 + b]);
            tag_q.push_back(TAG_WIDTH'(tag));
        end
    endtask

    task automatic expect_stream(input int it);
        for (int k = 0; k < 16; k++) begin
            stream_q.push_back(ref_mem[it * 16 + k]);
        end
    endtask

    // one-cycle strobes, stream start either by stream_begin or by a new iter
    task automatic issue(input bit do_edge, input bit do_begin, input op_t e);
        @(posedge clk);
        if (do_edge) begin
            rd_valid <= 1'b1;
            rd_node  <= NODE_ID_WIDTH'(e.node);
            rd_tag   <= TAG_WIDTH'(e.tag);
        end
        stream_begin <= do_begin;
        iter         <= ITER_WIDTH'(e.it);
        @(posedge clk);
        rd_valid     <= 1'b0;
        stream_begin <= 1'b0;
        wait_idle();
    endtask

    task automatic idle_check();
        repeat (12) begin
            @(negedge clk);
            assert (available) else begin
                $display("bank not available while no operation is running");
                report_failure();
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset && edge_valid) begin
            assert (edge_q.size() != 0) else begin
                $display("edge beat arrived with no read outstanding");
                report_failure();
            end
            exp_data = edge_q.pop_front();
            exp_tag  = tag_q.pop_front();
            assert (edge_data == exp_data) else begin
                $display("ERROR edge_data: got %h expected %h", edge_data, exp_data);
                report_failure();
            end
            assert (edge_tag == exp_tag) else begin
                $display("ERROR edge_tag: got %h expected %h", edge_tag, exp_tag);
                report_failure();
            end
            assert (edge_sos == (edge_beat == 0) && edge_eos == (edge_beat == 3)) else begin
                $display("ERROR edge_sos/edge_eos: got %h/%h at beat %h",
                         edge_sos, edge_eos, edge_beat);
                report_failure();
            end
            edge_beat = (edge_beat + 1) % 4;
        end
        if (!reset && stream_valid) begin
            assert (stream_q.size() != 0) else begin
                $display("stream beat arrived with no stream started");
                report_failure();
            end
            exp_data = stream_q.pop_front();
            assert (stream_data == exp_data) else begin
                $display("ERROR stream_data: got %h expected %h", stream_data, exp_data);
                report_failure();
            end
            assert (stream_idx == STREAM_IDX_WIDTH'(stream_beat)) else begin
                $display("ERROR stream_idx: got %h expected %h", stream_idx, stream_beat);
                report_failure();
            end
            assert (stream_sos == (stream_beat == 0) && stream_eos == (stream_beat == 15))
            else begin
                $display("ERROR stream_sos/stream_eos: got %h/%h at beat %h",
                         stream_sos, stream_eos, stream_beat);
                report_failure();
            end
            stream_beat = (stream_beat + 1) % 16;
        end
    end

    initial begin
        repeat (200 * (N_OPS + 2)) @(posedge clk);
        $display("timeout, the operations did not finish in time");
        report_failure();
    end

    initial begin
        reset        = 1'b1;
        stream_begin = 1'b0;
        iter         = '0;
        rd_valid     = 1'b0;
        rd_node      = '0;
        rd_tag       = '0;
        wb_valid     = 1'b0;
        wb_node      = '0;
        wb_data      = '0;
        wb_last      = 1'b0;
        rng_state    = 32'd36015;
        error_count  = 0;
        edge_beat    = 0;
        stream_beat  = 0;

        // nodes 0..7 fill iterations 0 and 1, then reads, streams and contention
        ops[0]  = '{OP_WRITE, 0, 0, 0};
        ops[1]  = '{OP_WRITE, 1, 0, 0};
        ops[2]  = '{OP_WRITE, 2, 0, 0};
        ops[3]  = '{OP_WRITE, 3, 0, 0};
        ops[4]  = '{OP_EDGE, 2, 1, 0};
        ops[5]  = '{OP_STREAM, 0, 0, 0};
        ops[6]  = '{OP_IDLE, 0, 0, 0};
        ops[7]  = '{OP_WRITE, 4, 0, 0};
        ops[8]  = '{OP_WRITE, 5, 0, 0};
        ops[9]  = '{OP_WRITE, 6, 0, 0};
        ops[10] = '{OP_WRITE, 7, 0, 0};
        ops[11] = '{OP_ITER, 0, 0, 1};
        ops[12] = '{OP_IDLE, 0, 0, 1};
        ops[13] = '{OP_WRITE, 1, 0, 1};
        ops[14] = '{OP_BOTH, 1, 3, 1};
        ops[15] = '{OP_EDGE, 6, 2, 1};
        ops[16] = '{OP_BOTH, 0, 0, 0};
        ops[17] = '{OP_IDLE, 0, 0, 0};

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (available && !stream_valid && !edge_valid) else begin
            $display("outputs not idle after reset");
            report_failure();
        end

        for (int i = 0; i < N_OPS; i++) begin
            case (ops[i].op)
                OP_WRITE: write_node(ops[i].node);
                OP_EDGE: begin
                    expect_edge(ops[i].node, ops[i].tag);
                    issue(1'b1, 1'b0, ops[i]);
                end
                OP_STREAM: begin
                    expect_stream(ops[i].it);
                    issue(1'b0, 1'b1, ops[i]);
                end
                OP_ITER: begin
                    expect_stream(ops[i].it);
                    issue(1'b0, 1'b0, ops[i]);
                end
                OP_BOTH: begin
                    expect_edge(ops[i].node, ops[i].tag);
                    expect_stream(ops[i].it);
                    issue(1'b1, 1'b1, ops[i]);
                end
                default: idle_check();
            endcase
        end

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "errors were found");
        end
    end

endmodule

`default_nettype wire

// ==== tests/fv_bank_props.sv ====
// arbiter properties, one grant at a time, bank access only with an owner, grants held
`timescale 1ns/1ps
`default_nettype none

module fv_bank_props (
    input wire             clk,
    input wire             reset,
    input wire             req_write,
    input wire             req_edge,
    input wire             req_stream,
    input wire             gnt_write,
    input wire             gnt_edge,
    input wire             gnt_stream,
    input wire             sram_en,
    input wire fv_pkg::client_t owner
);
    import fv_pkg::*;

    one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({gnt_write, gnt_edge, gnt_stream}))
        else $error("more than one grant is high");

    en_needs_owner: assert property (@(posedge clk) disable iff (reset)
        sram_en |-> (owner != CL_NONE))
        else $error("SRAM enabled without an owner");

    write_held: assert property (@(posedge clk) disable iff (reset)
        (gnt_write && req_write) |=> gnt_write)
        else $error("write grant dropped while requested");

    edge_held: assert property (@(posedge clk) disable iff (reset)
        (gnt_edge && req_edge) |=> gnt_edge)
        else $error("edge grant dropped while requested");

    stream_held: assert property (@(posedge clk) disable iff (reset)
        (gnt_stream && req_stream) |=> gnt_stream)
        else $error("stream grant dropped while requested");

endmodule

bind fv_bank_arbiter fv_bank_props u_props (.*);

`default_nettype wire

// ==== source/fv_bank_top.sv ====
// feature-value bank top, SRAM plus arbiter and its three clients
`timescale 1ns/1ps
`default_nettype none

module fv_bank_top (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 stream_begin,
    input  wire [fv_pkg::ITER_WIDTH-1:0]        iter,
    input  wire                                 rd_valid,
    input  wire [fv_pkg::NODE_ID_WIDTH-1:0]     rd_node,
    input  wire [fv_pkg::TAG_WIDTH-1:0]         rd_tag,
    input  wire                                 wb_valid,
    input  wire [fv_pkg::NODE_ID_WIDTH-1:0]     wb_node,
    input  wire [fv_pkg::FV_WIDTH-1:0]          wb_data,
    input  wire                                 wb_last,
    output logic                                available,
    output logic                                stream_valid,
    output logic                                stream_sos,
    output logic                                stream_eos,
    output logic [fv_pkg::STREAM_IDX_WIDTH-1:0] stream_idx,
    output logic [fv_pkg::FV_WIDTH-1:0]         stream_data,
    output logic                                edge_valid,
    output logic                                edge_sos,
    output logic                                edge_eos,
    output logic [fv_pkg::TAG_WIDTH-1:0]        edge_tag,
    output logic [fv_pkg::FV_WIDTH-1:0]         edge_data
);
    import fv_pkg::*;

    logic                  sram_en;
    logic                  sram_we;
    logic [ADDR_WIDTH-1:0] sram_addr;
    logic [FV_WIDTH-1:0]   sram_wdata;
    logic [FV_WIDTH-1:0]   sram_rdata;

    logic                  req_write, gnt_write, en_write, we_write;
    logic [ADDR_WIDTH-1:0] addr_write;
    logic [FV_WIDTH-1:0]   wdata_write;
    logic                  filling;
    logic                  req_edge, gnt_edge, en_edge;
    logic [ADDR_WIDTH-1:0] addr_edge;
    logic                  req_stream, gnt_stream, en_stream;
    logic [ADDR_WIDTH-1:0] addr_stream;

    fv_sram u_sram (
        .clk(clk), .en(sram_en), .we(sram_we), .addr(sram_addr),
        .wdata(sram_wdata), .rdata(sram_rdata)
    );

    fv_bank_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .req_write(req_write), .req_edge(req_edge), .req_stream(req_stream),
        .gnt_write(gnt_write), .gnt_edge(gnt_edge), .gnt_stream(gnt_stream),
        .en_write(en_write), .we_write(we_write), .addr_write(addr_write),
        .wdata_write(wdata_write), .en_edge(en_edge), .addr_edge(addr_edge),
        .en_stream(en_stream), .addr_stream(addr_stream), .filling(filling),
        .sram_en(sram_en), .sram_we(sram_we), .sram_addr(sram_addr),
        .sram_wdata(sram_wdata), .available(available)
    );

    fv_stream_reader u_stream (
        .clk(clk), .reset(reset), .stream_begin(stream_begin), .iter(iter),
        .gnt(gnt_stream), .rdata(sram_rdata), .req(req_stream), .en(en_stream),
        .addr(addr_stream), .stream_valid(stream_valid), .stream_sos(stream_sos),
        .stream_eos(stream_eos), .stream_idx(stream_idx), .stream_data(stream_data)
    );

    fv_edge_reader u_edge (
        .clk(clk), .reset(reset), .rd_valid(rd_valid), .rd_node(rd_node),
        .rd_tag(rd_tag), .gnt(gnt_edge), .rdata(sram_rdata), .req(req_edge),
        .en(en_edge), .addr(addr_edge), .edge_valid(edge_valid), .edge_sos(edge_sos),
        .edge_eos(edge_eos), .edge_tag(edge_tag), .edge_data(edge_data)
    );

    fv_write_port u_write (
        .clk(clk), .reset(reset), .wb_valid(wb_valid), .wb_node(wb_node),
        .wb_data(wb_data), .wb_last(wb_last), .gnt(gnt_write), .req(req_write),
        .en(en_write), .we(we_write), .addr(addr_write), .wdata(wdata_write),
        .filling(filling)
    );

endmodule

`default_nettype wire

// ==== source/fv_write_port.sv ====
// write-back collector, buffers four beats then writes them as one burst
`timescale 1ns/1ps
`default_nettype none

module fv_write_port (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             wb_valid,
    input  wire [fv_pkg::NODE_ID_WIDTH-1:0] wb_node,
    input  wire [fv_pkg::FV_WIDTH-1:0]      wb_data,
    input  wire                             wb_last,
    input  wire                             gnt,
    output logic                            req,
    output logic                            en,
    output logic                            we,
    output logic [fv_pkg::ADDR_WIDTH-1:0]   addr,
    output logic [fv_pkg::FV_WIDTH-1:0]     wdata,
    output logic                            filling
);
    import fv_pkg::*;

    ctl_state_t                state;
    logic [NODE_ID_WIDTH-1:0]  node_q;
    logic [LINE_SEL_WIDTH-1:0] cnt;
    logic [FV_WIDTH-1:0]       line_buf [1 << LINE_SEL_WIDTH];

    assign req     = (state == ACQUIRE) || (state == ACCESS);
    assign en      = req && gnt;
    assign we      = en;
    assign addr    = {node_q, cnt};
    assign wdata   = line_buf[cnt];
    // mid-collection, between the first beat and wb_last
    assign filling = (state == IDLE) && (cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (wb_valid) begin
                        cnt <= wb_last ? '0 : cnt + 1'b1;
                        if (wb_last) begin
                            state <= ACQUIRE;
                        end
                    end
                end
                ACQUIRE, ACCESS: begin
                    if (en) begin
                        cnt   <= cnt + 1'b1;
                        state <= (cnt == '1) ? DRAIN : ACCESS;
                    end
                end
                // req is low here, owner releases at this edge
                DRAIN:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && wb_valid) begin
            line_buf[cnt] <= wb_data;
            if (cnt == '0) begin
                node_q <= wb_node;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fv_edge_reader.sv ====
// per-node read engine, returns four tagged lines to an edge PE
`timescale 1ns/1ps
`default_nettype none

module fv_edge_reader (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           rd_valid,
    input  wire [fv_pkg::NODE_ID_WIDTH-1:0] rd_node,
    input  wire [fv_pkg::TAG_WIDTH-1:0]   rd_tag,
    input  wire                           gnt,
    input  wire [fv_pkg::FV_WIDTH-1:0]    rdata,
    output logic                          req,
    output logic                          en,
    output logic [fv_pkg::ADDR_WIDTH-1:0] addr,
    output logic                          edge_valid,
    output logic                          edge_sos,
    output logic                          edge_eos,
    output logic [fv_pkg::TAG_WIDTH-1:0]  edge_tag,
    output logic [fv_pkg::FV_WIDTH-1:0]   edge_data
);
    import fv_pkg::*;

    ctl_state_t                state;
    logic [NODE_ID_WIDTH-1:0]  node_q;
    logic [TAG_WIDTH-1:0]      tag_q;
    logic [LINE_SEL_WIDTH-1:0] cnt;
    logic [LINE_SEL_WIDTH-1:0] rd_line;
    logic                      rd_pend;

    assign req  = (state == ACQUIRE) || (state == ACCESS);
    assign en   = req && gnt;
    assign addr = {node_q, cnt};

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            cnt        <= '0;
            rd_pend    <= 1'b0;
            edge_valid <= 1'b0;
            edge_sos   <= 1'b0;
            edge_eos   <= 1'b0;
        end else begin
            rd_pend    <= en;
            edge_valid <= rd_pend;
            edge_sos   <= rd_pend && (rd_line == '0);
            edge_eos   <= rd_pend && (rd_line == '1);
            case (state)
                IDLE: begin
                    if (rd_valid) begin
                        cnt   <= '0;
                        state <= ACQUIRE;
                    end
                end
                ACQUIRE, ACCESS: begin
                    if (en) begin
                        cnt   <= cnt + 1'b1;
                        state <= (cnt == '1) ? DRAIN : ACCESS;
                    end
                end
                DRAIN: begin
                    if (!rd_pend) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if ((state == IDLE) && rd_valid) begin
            node_q <= rd_node;
            tag_q  <= rd_tag;
        end
        if (en) begin
            rd_line <= cnt;
        end
        edge_tag  <= tag_q;
        edge_data <= rdata;
    end

endmodule

`default_nettype wire

// ==== source/fv_stream_reader.sv ====
// iteration stream engine, reads sixteen lines and frames them for the feature buffer
`timescale 1ns/1ps
`default_nettype none

module fv_stream_reader (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 stream_begin,
    input  wire [fv_pkg::ITER_WIDTH-1:0]        iter,
    input  wire                                 gnt,
    input  wire [fv_pkg::FV_WIDTH-1:0]          rdata,
    output logic                                req,
    output logic                                en,
    output logic [fv_pkg::ADDR_WIDTH-1:0]       addr,
    output logic                                stream_valid,
    output logic                                stream_sos,
    output logic                                stream_eos,
    output logic [fv_pkg::STREAM_IDX_WIDTH-1:0] stream_idx,
    output logic [fv_pkg::FV_WIDTH-1:0]         stream_data
);
    import fv_pkg::*;

    ctl_state_t                  state;
    logic [ITER_WIDTH-1:0]       cur_iter;
    logic [STREAM_IDX_WIDTH-1:0] cnt;
    logic [STREAM_IDX_WIDTH-1:0] rd_idx;
    logic                        rd_pend;
    logic                        start;

    // a new iteration value restarts the replay on its own
    assign start = stream_begin || (iter != cur_iter);

    assign req  = (state == ACQUIRE) || (state == ACCESS);
    assign en   = req && gnt;
    assign addr = {{(ADDR_WIDTH - ITER_WIDTH - STREAM_IDX_WIDTH){1'b0}}, cur_iter, cnt};

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            cur_iter     <= '0;
            cnt          <= '0;
            rd_pend      <= 1'b0;
            stream_valid <= 1'b0;
            stream_sos   <= 1'b0;
            stream_eos   <= 1'b0;
        end else begin
            rd_pend      <= en;
            stream_valid <= rd_pend;
            stream_sos   <= rd_pend && (rd_idx == '0);
            stream_eos   <= rd_pend && (rd_idx == '1);
            case (state)
                IDLE: begin
                    if (start) begin
                        cur_iter <= iter;
                        cnt      <= '0;
                        state    <= ACQUIRE;
                    end
                end
                ACQUIRE, ACCESS: begin
                    if (en) begin
                        cnt   <= cnt + 1'b1;
                        state <= (cnt == '1) ? DRAIN : ACCESS;
                    end
                end
                DRAIN: begin
                    // wait for the last line to leave the pipe
                    if (!rd_pend) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // local index trails the read by one cycle, like the data
    always_ff @(posedge clk) begin
        if (en) begin
            rd_idx <= cnt;
        end
        stream_idx  <= rd_idx;
        stream_data <= rdata;
    end

endmodule

`default_nettype wire

// ==== source/fv_bank_arbiter.sv ====
// fixed-priority, burst-locked arbiter for the feature bank
// muxes the owning client onto the SRAM and derives available
`timescale 1ns/1ps
`default_nettype none

module fv_bank_arbiter (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           req_write,
    input  wire                           req_edge,
    input  wire                           req_stream,
    output logic                          gnt_write,
    output logic                          gnt_edge,
    output logic                          gnt_stream,
    input  wire                           en_write,
    input  wire                           we_write,
    input  wire [fv_pkg::ADDR_WIDTH-1:0]  addr_write,
    input  wire [fv_pkg::FV_WIDTH-1:0]    wdata_write,
    input  wire                           en_edge,
    input  wire [fv_pkg::ADDR_WIDTH-1:0]  addr_edge,
    input  wire                           en_stream,
    input  wire [fv_pkg::ADDR_WIDTH-1:0]  addr_stream,
    input  wire                           filling,
    output logic                          sram_en,
    output logic                          sram_we,
    output logic [fv_pkg::ADDR_WIDTH-1:0] sram_addr,
    output logic [fv_pkg::FV_WIDTH-1:0]   sram_wdata,
    output logic                          available
);
    import fv_pkg::*;

    client_t               owner;
    client_t               owner_nx;
    logic                  owner_req;
    logic [CLIENT_NUM-1:0] req_vec;

    assign req_vec = {req_stream, req_edge, req_write};

    always_comb begin
        case (owner)
            CL_WRITE:  owner_req = req_write;
            CL_EDGE:   owner_req = req_edge;
            CL_STREAM: owner_req = req_stream;
            default:   owner_req = 1'b0;
        endcase
    end

    // grant once, then hold for the whole burst
    always_comb begin
        owner_nx = owner;
        if (owner == CL_NONE) begin
            if (req_write) begin
                owner_nx = CL_WRITE;
            end else if (req_edge) begin
                owner_nx = CL_EDGE;
            end else if (req_stream) begin
                owner_nx = CL_STREAM;
            end
        end else if (!owner_req) begin
            owner_nx = CL_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= CL_NONE;
        end else begin
            owner <= owner_nx;
        end
    end

    assign gnt_write  = (owner == CL_WRITE);
    assign gnt_edge   = (owner == CL_EDGE);
    assign gnt_stream = (owner == CL_STREAM);

    // only the writer ever drives we
    always_comb begin
        sram_we    = 1'b0;
        sram_wdata = wdata_write;
        case (owner)
            CL_WRITE: begin
                sram_en   = en_write;
                sram_we   = we_write;
                sram_addr = addr_write;
            end
            CL_EDGE: begin
                sram_en   = en_edge;
                sram_addr = addr_edge;
            end
            CL_STREAM: begin
                sram_en   = en_stream;
                sram_addr = addr_stream;
            end
            default: begin
                sram_en   = 1'b0;
                sram_addr = addr_stream;
            end
        endcase
    end

    assign available = (owner == CL_NONE) && !(|req_vec) && !filling;

endmodule

`default_nettype wire

// ==== source/fv_sram.sv ====
// single-port feature SRAM bank, one-cycle read latency
`timescale 1ns/1ps
`default_nettype none

module fv_sram (
    input  wire                          clk,
    input  wire                          en,
    input  wire                          we,
    input  wire [fv_pkg::ADDR_WIDTH-1:0] addr,
    input  wire [fv_pkg::FV_WIDTH-1:0]   wdata,
    output logic [fv_pkg::FV_WIDTH-1:0]  rdata
);
    import fv_pkg::*;

    // 64 nodes x 4 lines
    logic [FV_WIDTH-1:0] mem [1 << ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fv_pkg.sv ====
// feature-value bank geometry, client engine states and arbiter owner codes
`default_nettype none

package fv_pkg;

    // one feature line and the node layout of the bank
    localparam int FV_WIDTH         = 32;
    localparam int NODE_ID_WIDTH    = 6;
    localparam int LINE_SEL_WIDTH   = 2;
    localparam int ADDR_WIDTH       = NODE_ID_WIDTH + LINE_SEL_WIDTH;

    // replay iteration covers four nodes, sixteen lines
    localparam int ITER_WIDTH       = 2;
    localparam int STREAM_IDX_WIDTH = 4;

    localparam int TAG_WIDTH        = 2;
    localparam int CLIENT_NUM       = 3;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACQUIRE = 2'd1,
        ACCESS  = 2'd2,
        DRAIN   = 2'd3
    } ctl_state_t;

    // listed in priority order, write first
    typedef enum logic [1:0] {
        CL_NONE   = 2'd0,
        CL_WRITE  = 2'd1,
        CL_EDGE   = 2'd2,
        CL_STREAM = 2'd3
    } client_t;

endpackage

`default_nettype wire
